// ==== Bender.yml ====
package:
  name: eth_switch

sources:
  - eth_pkg.sv
  - switch_pkg.sv
  - sw_port_rx.sv
  - mac_table.sv
  - sw_fwd_engine.sv
  - eth_switch.sv
  - target: simulation
    files:
      - tb_eth_switch_props.sv
      - tb_eth_switch.sv

// ==== eth_pkg.sv ====
package eth_pkg;

  localparam int HDR_LEN   = 14;
  localparam int MAX_FRAME = 64;
  localparam int MAC_LEN   = 6;
  // frame lengths need one bit more than buffer addresses
  localparam int BUF_AW    = $clog2(MAX_FRAME);

  typedef logic [7:0] byte_t;

  // first octet on the wire sits in the top byte of raw
  typedef union packed {
    logic [8*MAC_LEN-1:0] raw;
    byte_t [0:MAC_LEN-1]  oct;
  } mac_addr_u;

  typedef struct packed {
    byte_t dat;
    logic  val;
  } phy_t;

  // group bit is bit 0 of the first octet
  function automatic logic is_group(mac_addr_u addr);
    return addr.oct[0][0];
  endfunction

endpackage

// ==== eth_switch.sv ====
`timescale 1ns/100ps

module eth_switch
  import eth_pkg::*, switch_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  phy_t      phy_in  [N_PORTS],
  output phy_t      phy_out [N_PORTS],
  output sw_stats_t stats
);

  lookup_req_t       req [N_PORTS];
  lookup_rsp_t       rsp [N_PORTS];
  logic [BUF_AW:0]   frame_len [N_PORTS];
  port_mask_t        mask [N_PORTS];
  byte_t             rd_data [N_PORTS];
  logic [BUF_AW-1:0] rd_addr;
  port_mask_t        ready;
  port_mask_t        done;
  port_mask_t        drop;
  port_mask_t        empty_done;
  logic [2:0]        drop_inc;
  logic [15:0]       fwd_cnt;
  logic [15:0]       drop_cnt;

  ////////////////////////////////////////////////////////////
  // ingress ports
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < N_PORTS; i++) begin : g_port
    sw_port_rx u_port (
      .clk        (clk),
      .rst_n      (rst_n),
      .phy_in     (phy_in[i]),
      .lookup_req (req[i]),
      .lookup_rsp (rsp[i]),
      .ready      (ready[i]),
      .frame_len  (frame_len[i]),
      .mask       (mask[i]),
      .rd_addr    (rd_addr),
      .rd_data    (rd_data[i]),
      .done       (done[i]),
      .drop       (drop[i])
    );
    // filtered frame, mask still held when done arrives
    assign empty_done[i] = done[i] & (mask[i] == '0);
  end

  mac_table u_table (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .rsp   (rsp)
  );

  sw_fwd_engine u_engine (
    .clk       (clk),
    .rst_n     (rst_n),
    .ready     (ready),
    .frame_len (frame_len),
    .mask      (mask),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .grant     (),
    .done      (done),
    .phy_out   (phy_out),
    .fwd_cnt   (fwd_cnt)
  );

  // runts, busy drops and filtered frames
  always_comb begin
    drop_inc = '0;
    for (int i = 0; i < N_PORTS; i++) begin
      drop_inc = drop_inc + drop[i] + empty_done[i];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      drop_cnt <= '0;
    end else begin
      drop_cnt <= drop_cnt + 16'(drop_inc);
    end
  end

  assign stats.fwd_cnt  = fwd_cnt;
  assign stats.drop_cnt = drop_cnt;

endmodule

// ==== mac_table.sv ====
`timescale 1ns/100ps

module mac_table
  import eth_pkg::*, switch_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  lookup_req_t req [N_PORTS],
  output lookup_rsp_t rsp [N_PORTS]
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOOK,
    ST_HOLD
  } state_t;

  state_t                state;
  port_idx_t             cur;
  port_idx_t             rr;
  port_mask_t            pend;
  port_mask_t            ack_q;
  port_mask_t            mask_q;
  port_mask_t            req_bit;
  port_mask_t            new_mask;
  lookup_req_t           cur_req;
  logic [TABLE_SIZE-1:0] tab_vld;
  mac_addr_u             tab_mac  [TABLE_SIZE];
  port_idx_t             tab_port [TABLE_SIZE];
  logic [TABLE_AW-1:0]   repl_ptr;
  logic [TABLE_AW-1:0]   src_idx;
  logic [TABLE_AW-1:0]   free_idx;
  logic [TABLE_AW-1:0]   learn_idx;
  logic                  src_hit;
  logic                  free_hit;
  logic                  dst_hit;
  port_idx_t             dst_port;

  always_comb begin
    for (int i = 0; i < N_PORTS; i++) begin
      pend[i]     = req[i].req & ~ack_q[i];
      rsp[i].ack  = ack_q[i];
      rsp[i].mask = ack_q[i] ? mask_q : '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // search and mask for the request being served
  ////////////////////////////////////////////////////////////

  always_comb begin
    cur_req  = req[cur];
    src_hit  = 1'b0;
    src_idx  = '0;
    free_hit = 1'b0;
    free_idx = '0;
    dst_hit  = 1'b0;
    dst_port = '0;
    // scan downward, lowest matching index wins
    for (int i = TABLE_SIZE - 1; i >= 0; i--) begin
      if (tab_vld[i] && tab_mac[i].raw == cur_req.src.raw) begin
        src_hit = 1'b1;
        src_idx = TABLE_AW'(i);
      end
      if (!tab_vld[i]) begin
        free_hit = 1'b1;
        free_idx = TABLE_AW'(i);
      end
      if (tab_vld[i] && tab_mac[i].raw == cur_req.dst.raw) begin
        dst_hit  = 1'b1;
        dst_port = tab_port[i];
      end
    end
    learn_idx = src_hit ? src_idx : (free_hit ? free_idx : repl_ptr);
    req_bit   = port_mask_t'(1) << cur;
    if (is_group(cur_req.dst) || !dst_hit) begin
      new_mask = ~req_bit;
    end else if (dst_port == cur) begin
      new_mask = '0;
    end else begin
      new_mask = port_mask_t'(1) << dst_port;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      cur      <= '0;
      rr       <= '0;
      ack_q    <= '0;
      tab_vld  <= '0;
      repl_ptr <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (|pend) begin
            cur   <= rr_pick(pend, rr);
            state <= ST_LOOK;
          end
        end
        ST_LOOK: begin
          ack_q[cur]         <= 1'b1;
          tab_vld[learn_idx] <= 1'b1;
          rr                 <= next_port(cur);
          state              <= ST_HOLD;
          // table full, evict oldest slot
          if (!src_hit && !free_hit) begin
            repl_ptr <= (repl_ptr == TABLE_AW'(TABLE_SIZE - 1)) ? '0 : repl_ptr + 1'b1;
          end
        end
        ST_HOLD: begin
          if (!cur_req.req) begin
            ack_q <= '0;
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_LOOK) begin
      tab_mac[learn_idx]  <= cur_req.src;
      tab_port[learn_idx] <= cur;
      mask_q              <= new_mask;
    end
  end

endmodule

// ==== sim.f ====
eth_pkg.sv
switch_pkg.sv
sw_port_rx.sv
mac_table.sv
sw_fwd_engine.sv
eth_switch.sv
tb_eth_switch_props.sv
tb_eth_switch.sv

// ==== sw_fwd_engine.sv ====
`timescale 1ns/100ps

module sw_fwd_engine
  import eth_pkg::*, switch_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  port_mask_t        ready,
  input  logic [BUF_AW:0]   frame_len [N_PORTS],
  input  port_mask_t        mask [N_PORTS],
  output logic [BUF_AW-1:0] rd_addr,
  input  byte_t             rd_data [N_PORTS],
  output port_mask_t        grant,
  output port_mask_t        done,
  output phy_t              phy_out [N_PORTS],
  output logic [15:0]       fwd_cnt
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SEND,
    ST_GAP
  } state_t;

  state_t           state;
  port_idx_t        cur;
  port_idx_t        rr;
  port_idx_t        pick;
  port_mask_t       avail;
  port_mask_t       out_mask;
  port_mask_t       val_q;
  byte_t            dat_q;
  logic [IFG_W-1:0] gap_cnt;
  logic             last;

  // a port that just got done still shows ready for one cycle
  assign avail    = ready & ~done;
  assign pick     = rr_pick(avail, rr);
  assign out_mask = mask[cur];
  assign last     = ({1'b0, rd_addr} == (BUF_AW+1)'(frame_len[cur] - 1'b1));

  ////////////////////////////////////////////////////////////
  // grant, stream, gap
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      cur     <= '0;
      rr      <= '0;
      grant   <= '0;
      done    <= '0;
      rd_addr <= '0;
      val_q   <= '0;
      gap_cnt <= '0;
      fwd_cnt <= '0;
    end else begin
      done <= '0;
      case (state)
        ST_IDLE: begin
          if (|avail) begin
            cur     <= pick;
            grant   <= port_mask_t'(1) << pick;
            rd_addr <= '0;
            state   <= ST_SEND;
          end
        end
        ST_SEND: begin
          val_q   <= out_mask;
          rd_addr <= rd_addr + 1'b1;
          if (last || out_mask == '0) begin
            grant   <= '0;
            done    <= grant;
            rr      <= next_port(cur);
            gap_cnt <= '0;
            // filtered frame, nothing went out so no gap
            if (out_mask == '0) begin
              state <= ST_IDLE;
            end else begin
              state   <= ST_GAP;
              fwd_cnt <= fwd_cnt + 1'b1;
            end
          end
        end
        ST_GAP: begin
          val_q <= '0;
          // idle and grant cycles close the gap to IFG
          if (gap_cnt == IFG_W'(IFG - 2)) begin
            state <= ST_IDLE;
          end else begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_SEND) begin
      dat_q <= rd_data[cur];
    end
  end

  // every output carries the same byte, val selects the ports
  always_comb begin
    for (int i = 0; i < N_PORTS; i++) begin
      phy_out[i].dat = dat_q;
      phy_out[i].val = val_q[i];
    end
  end

endmodule

// ==== sw_port_rx.sv ====
`timescale 1ns/100ps

module sw_port_rx
  import eth_pkg::*, switch_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  phy_t              phy_in,
  output lookup_req_t       lookup_req,
  input  lookup_rsp_t       lookup_rsp,
  output logic              ready,
  output logic [BUF_AW:0]   frame_len,
  output port_mask_t        mask,
  input  logic [BUF_AW-1:0] rd_addr,
  output byte_t             rd_data,
  input  logic              done,
  output logic              drop
);

  byte_t           mem [MAX_FRAME];
  mac_addr_u       dst_q;
  mac_addr_u       src_q;
  logic            in_frame;
  logic            discard;
  logic            busy;
  logic            req_q;
  logic [BUF_AW:0] cnt;
  logic [BUF_AW:0] wr_idx;
  logic            sof;
  logic            eof;
  logic            wr_en;
  logic            ack_seen;

  assign sof      = phy_in.val & ~in_frame;
  assign eof      = ~phy_in.val & in_frame;
  // a new frame restarts at byte 0
  assign wr_idx   = sof ? '0 : cnt;
  // bytes past MAX_FRAME are cut off
  assign wr_en    = phy_in.val & (sof ? ~busy : ~discard) & (wr_idx < MAX_FRAME);
  assign ack_seen = req_q & lookup_rsp.ack;

  ////////////////////////////////////////////////////////////
  // frame capture and ownership
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_frame <= 1'b0;
      discard  <= 1'b0;
      busy     <= 1'b0;
      req_q    <= 1'b0;
      ready    <= 1'b0;
      drop     <= 1'b0;
      cnt      <= '0;
    end else begin
      in_frame <= phy_in.val;
      drop     <= 1'b0;
      if (sof) begin
        // still holding an unsent frame, this one is lost
        discard <= busy;
        drop    <= busy;
        if (!busy) begin
          busy <= 1'b1;
        end
      end
      if (wr_en) begin
        cnt <= wr_idx + 1'b1;
      end
      if (eof && !discard) begin
        if (cnt >= HDR_LEN) begin
          req_q <= 1'b1;
        end else begin
          // runt, free the buffer straight away
          busy <= 1'b0;
          drop <= 1'b1;
        end
      end
      if (ack_seen) begin
        req_q <= 1'b0;
        ready <= 1'b1;
      end
      if (done) begin
        busy  <= 1'b0;
        ready <= 1'b0;
      end
    end
  end

  // buffer, header and latched mask
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_idx[BUF_AW-1:0]] <= phy_in.dat;
      if (wr_idx < MAC_LEN) begin
        dst_q.raw <= {dst_q.raw[8*MAC_LEN-9:0], phy_in.dat};
      end else if (wr_idx < 2 * MAC_LEN) begin
        src_q.raw <= {src_q.raw[8*MAC_LEN-9:0], phy_in.dat};
      end
    end
    if (ack_seen) begin
      mask <= lookup_rsp.mask;
    end
  end

  assign lookup_req.dst = dst_q;
  assign lookup_req.src = src_q;
  assign lookup_req.req = req_q;

  assign frame_len = cnt;
  assign rd_data   = mem[rd_addr];

endmodule

// ==== switch_pkg.sv ====
package switch_pkg;

  import eth_pkg::*;

  localparam int N_PORTS    = 3;
  localparam int TABLE_SIZE = 8;
  localparam int TABLE_AW   = $clog2(TABLE_SIZE);
  localparam int IFG        = 10;
  localparam int IFG_W      = $clog2(IFG);

  typedef logic [N_PORTS-1:0] port_mask_t;
  typedef logic [1:0]         port_idx_t;

  typedef struct packed {
    mac_addr_u dst;
    mac_addr_u src;
    logic      req;
  } lookup_req_t;

  typedef struct packed {
    port_mask_t mask;
    logic       ack;
  } lookup_rsp_t;

  typedef struct packed {
    logic [15:0] fwd_cnt;
    logic [15:0] drop_cnt;
  } sw_stats_t;

  function automatic port_idx_t next_port(port_idx_t p);
    return (p == port_idx_t'(N_PORTS - 1)) ? '0 : p + 1'b1;
  endfunction

  // first pending port at or after start, wrapping around
  function automatic port_idx_t rr_pick(port_mask_t pend, port_idx_t start);
    port_idx_t pick;
    port_idx_t idx;
    logic      found;
    found = 1'b0;
    pick  = start;
    idx   = start;
    for (int n = 0; n < N_PORTS; n++) begin
      if (!found && pend[idx]) begin
        found = 1'b1;
        pick  = idx;
      end
      idx = next_port(idx);
    end
    return pick;
  endfunction

endpackage

// ==== tb_eth_switch.sv ====
`timescale 1ns/100ps

module tb_eth_switch
  import eth_pkg::*, switch_pkg::*;
();

  localparam int N_ROWS      = 16;
  localparam int WATCHDOG_NS = N_ROWS * (MAX_FRAME + IFG + 40) * 4 * 2;

  localparam logic [47:0] MAC_A  = 48'h02_00_00_00_00_0a;
  localparam logic [47:0] MAC_B  = 48'h02_00_00_00_00_0b;
  localparam logic [47:0] MAC_C  = 48'h02_00_00_00_00_0c;
  localparam logic [47:0] MAC_D  = 48'h02_00_00_00_00_0d;
  localparam logic [47:0] MAC_E  = 48'h02_00_00_00_00_0e;
  localparam logic [47:0] MAC_F  = 48'h02_00_00_00_00_0f;
  localparam logic [47:0] MAC_G  = 48'h02_00_00_00_00_10;
  localparam logic [47:0] MAC_H  = 48'h02_00_00_00_00_11;
  localparam logic [47:0] MAC_I  = 48'h02_00_00_00_00_12;
  localparam logic [47:0] MAC_J  = 48'h02_00_00_00_00_13;
  localparam logic [47:0] MAC_M  = 48'h01_00_5e_00_00_01;
  localparam logic [47:0] MAC_BC = 48'hff_ff_ff_ff_ff_ff;

  typedef struct packed {
    port_idx_t  port;
    mac_addr_u  dst;
    mac_addr_u  src;
    logic [6:0] len;
    port_mask_t exp_mask;
    logic       exp_drop;
    logic       no_wait;
  } row_t;

  logic        clk = 1'b0;
  logic        rst_n;
  phy_t        phy_in  [N_PORTS];
  phy_t        phy_out [N_PORTS];
  sw_stats_t   stats;
  row_t        rows     [N_ROWS];
  string       row_name [N_ROWS];
  byte_t       sent     [N_ROWS][MAX_FRAME];
  byte_t       cap_q    [N_PORTS][$];
  int          exp_q    [N_PORTS][$];
  int          row_cnt;
  int          errors;
  int          checks;
  int          exp_fwd;
  int          exp_drop;
  logic [31:0] lfsr;

  eth_switch uut (
    .clk     (clk),
    .rst_n   (rst_n),
    .phy_in  (phy_in),
    .phy_out (phy_out),
    .stats   (stats)
  );

  bind sw_port_rx tb_eth_switch_props u_props (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (lookup_req.req),
    .ack   (lookup_rsp.ack),
    .val   ('0),
    .grant ('0)
  );

  bind sw_fwd_engine tb_eth_switch_props u_props (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (1'b0),
    .ack   (1'b0),
    .val   (val_q),
    .grant (grant)
  );

  always #2 clk = ~clk;

  task automatic check_eq(string what, int expected, int actual);
    checks++;
    if (expected != actual) begin
      errors++;
      $display("Fail %s: expected %0h, actual %0h", what, expected, actual);
    end
  endtask

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic byte_t next_byte();
    byte_t b;
    b = '0;
    for (int k = 0; k < 8; k++) begin
      lfsr = lfsr_step(lfsr);
      b    = {b[6:0], lfsr[0]};
    end
    return b;
  endfunction

  task automatic add_row(string name, int port, logic [47:0] dst, logic [47:0] src,
                         int len, port_mask_t mask, logic drop, logic no_wait);
    row_name[row_cnt]          = name;
    rows[row_cnt].port         = port_idx_t'(port);
    rows[row_cnt].dst.raw      = dst;
    rows[row_cnt].src.raw      = src;
    rows[row_cnt].len          = 7'(len);
    rows[row_cnt].exp_mask     = mask;
    rows[row_cnt].exp_drop     = drop;
    rows[row_cnt].no_wait      = no_wait;
    row_cnt++;
  endtask

  // header in wire order, then payload, then the outputs it should reach
  task automatic prepare_row(int r);
    for (int i = 0; i < MAC_LEN; i++) begin
      sent[r][i]           = rows[r].dst.oct[i];
      sent[r][MAC_LEN + i] = rows[r].src.oct[i];
    end
    for (int i = 2 * MAC_LEN; i < rows[r].len; i++) begin
      sent[r][i] = next_byte();
    end
    for (int p = 0; p < N_PORTS; p++) begin
      if (rows[r].exp_mask[p]) begin
        exp_q[p].push_back(r);
      end
    end
    if (rows[r].exp_drop) begin
      exp_drop++;
    end else if (rows[r].exp_mask != '0) begin
      exp_fwd++;
    end
  endtask

  task automatic send_frame(int r);
    for (int i = 0; i < rows[r].len; i++) begin
      @(posedge clk);
      #1;
      phy_in[rows[r].port].val = 1'b1;
      phy_in[rows[r].port].dat = sent[r][i];
    end
    @(posedge clk);
    #1;
    phy_in[rows[r].port] = '0;
  endtask

  function automatic int outstanding();
    int n;
    n = 0;
    for (int p = 0; p < N_PORTS; p++) begin
      n += exp_q[p].size() + cap_q[p].size();
    end
    return n;
  endfunction

  task automatic wait_settled(int r);
    do begin
      @(negedge clk);
    end while (stats.fwd_cnt < exp_fwd || stats.drop_cnt < exp_drop || outstanding() != 0);
    // a stray frame would finish inside the gap
    repeat (IFG + 2) @(negedge clk);
    check_eq({row_name[r], " fwd_cnt"}, exp_fwd, stats.fwd_cnt);
    check_eq({row_name[r], " drop_cnt"}, exp_drop, stats.drop_cnt);
  endtask

  ////////////////////////////////////////////////////////////
  // output monitors
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    int r;
    for (int p = 0; p < N_PORTS; p++) begin
      if (phy_out[p].val) begin
        cap_q[p].push_back(phy_out[p].dat);
      end else if (cap_q[p].size() > 0) begin
        if (exp_q[p].size() == 0) begin
          errors++;
          $display("Error: port %0d sent a frame that no row expected", p);
        end else begin
          r = exp_q[p].pop_front();
          check_eq($sformatf("%s port %0d length", row_name[r], p), rows[r].len,
                   cap_q[p].size());
          for (int i = 0; i < cap_q[p].size() && i < rows[r].len; i++) begin
            check_eq($sformatf("%s port %0d byte %0d", row_name[r], p, i), sent[r][i],
                     cap_q[p][i]);
          end
        end
        cap_q[p].delete();
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Error: timed out waiting for the switch to finish the frames");
    $display("*** TEST FAILED ***");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // stimulus table and main loop
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n    = 1'b0;
    row_cnt  = 0;
    errors   = 0;
    checks   = 0;
    exp_fwd  = 0;
    exp_drop = 0;
    lfsr     = 32'h17d8_a507;
    for (int p = 0; p < N_PORTS; p++) begin
      phy_in[p] = '0;
    end
    //      name             port dst     src    len mask    drop wait
    add_row("flood_unknown",  0, MAC_B,  MAC_A, 40, 3'b110, 0, 0);
    add_row("reply_learned",  1, MAC_A,  MAC_B, 30, 3'b001, 0, 0);
    add_row("to_server",      2, MAC_B,  MAC_C, 24, 3'b010, 0, 0);
    add_row("group_src",      1, MAC_C,  MAC_M, 20, 3'b100, 0, 0);
    add_row("group_learned",  2, MAC_M,  MAC_C, 18, 3'b011, 0, 0);
    add_row("broadcast",      0, MAC_BC, MAC_A, 16, 3'b110, 0, 0);
    add_row("filter_own",     0, MAC_A,  MAC_D, 20, 3'b000, 1, 0);
    add_row("runt",           1, MAC_A,  MAC_E, 10, 3'b000, 1, 0);
    add_row("busy_first",     2, MAC_A,  MAC_C, 64, 3'b001, 0, 1);
    add_row("busy_second",    2, MAC_B,  MAC_F, 20, 3'b000, 1, 1);
    add_row("learn_g",        1, MAC_C,  MAC_G, 16, 3'b100, 0, 0);
    add_row("learn_h",        1, MAC_C,  MAC_H, 16, 3'b100, 0, 0);
    add_row("learn_i",        0, MAC_C,  MAC_I, 16, 3'b100, 0, 0);
    add_row("learn_j_evict",  0, MAC_C,  MAC_J, 16, 3'b100, 0, 0);
    add_row("evicted_floods", 2, MAC_A,  MAC_C, 16, 3'b011, 0, 0);
    add_row("recent_unicast", 2, MAC_H,  MAC_C, 16, 3'b010, 0, 0);
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int r = 0; r < row_cnt; r++) begin
      prepare_row(r);
      send_frame(r);
      if (!rows[r].no_wait) begin
        wait_settled(r);
      end
    end
    errors += uut.g_port[0].u_port.u_props.fail_cnt;
    errors += uut.g_port[1].u_port.u_props.fail_cnt;
    errors += uut.g_port[2].u_port.u_props.fail_cnt;
    errors += uut.u_engine.u_props.fail_cnt;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== tb_eth_switch_props.sv ====
`timescale 1ns/100ps

module tb_eth_switch_props
  import switch_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input logic       req,
  input logic       ack,
  input port_mask_t val,
  input port_mask_t grant
);

  int fail_cnt = 0;

  ////////////////////////////////////////////////////////////
  // four-phase lookup handshake
  ////////////////////////////////////////////////////////////

  req_held: assert property (@(posedge clk) disable iff (!rst_n) req && !ack |=> req)
    else begin
      fail_cnt++;
      $error("lookup req fell before ack");
    end

  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> req)
    else begin
      fail_cnt++;
      $error("lookup ack rose without req");
    end

  ////////////////////////////////////////////////////////////
  // output stream rules
  ////////////////////////////////////////////////////////////

  // last beat seen, then IFG idle samples
  gap_kept: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(|val) |-> (!(|val)) [*IFG])
    else begin
      fail_cnt++;
      $error("output gap shorter than IFG");
    end

  // beats lag the grant by one cycle
  no_echo: assert property (@(posedge clk) disable iff (!rst_n) !(|(val & $past(grant))))
    else begin
      fail_cnt++;
      $error("frame sent back to its source port");
    end

endmodule
